/* source/mips_isa_pkg.sv */
`default_nettype none

package mips_isa_pkg;

    // Data and instruction words.
    typedef logic [31:0] word_t;
    typedef logic [31:0] instr_t;

    // Register index, five bits for 32 registers.
    typedef logic [4:0] reg_idx_t;

    // Primary opcode field, bits 31 to 26.
    typedef enum logic [5:0] {
        OP_SPECIAL = 6'h00,
        OP_REGIMM  = 6'h01,
        OP_ADDIU   = 6'h09,
        OP_LW      = 6'h23,
        OP_SW      = 6'h2b
    } opcode_t;

    // Function field of SPECIAL instructions.
    localparam logic [5:0] FUNCT_ADDU = 6'h21;
    localparam logic [5:0] FUNCT_JR   = 6'h08;

    // Rt field selects the REGIMM branch.
    localparam reg_idx_t RT_BLTZ = 5'h00;
    localparam reg_idx_t RT_BGEZ = 5'h01;

    localparam reg_idx_t REG_V0 = 5'd2;

endpackage

`default_nettype wire

/* source/mem_bus_pkg.sv */
`default_nettype none

package mem_bus_pkg;

    // Byte address on the bus.
    typedef logic [31:0] addr_t;

    // Word index into the RAM array.
    typedef logic [7:0] ram_idx_t;

    localparam int RAM_WORDS = 256;

    // First fetch address after start.
    localparam addr_t RESET_PC = 32'h4;

    // A jump here ends the run.
    localparam addr_t HALT_PC = 32'h0;

endpackage

`default_nettype wire

/* source/register_file.sv */
`default_nettype none

module register_file (
    input  wire logic                  clk,
    input  wire logic                  arst_n,
    input  wire logic                  we,
    input  wire mips_isa_pkg::reg_idx_t rs,
    input  wire mips_isa_pkg::reg_idx_t rt,
    input  wire mips_isa_pkg::reg_idx_t rd,
    input  wire mips_isa_pkg::word_t    wdata,
    output mips_isa_pkg::word_t         rs_data,
    output mips_isa_pkg::word_t         rt_data,
    output mips_isa_pkg::word_t         v0
);

    import mips_isa_pkg::*;

    word_t regs [32];

    // Two asynchronous read ports.
    assign rs_data = regs[rs];
    assign rt_data = regs[rt];
    assign v0      = regs[REG_V0];

    // R0 never changes.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && rd != '0) begin
            regs[rd] <= wdata;
        end
    end

endmodule

`default_nettype wire

/* source/fetch_unit.sv */
`default_nettype none

module fetch_unit (
    input  wire logic                 clk,
    input  wire logic                 arst_n,
    input  wire logic                 start,
    input  wire logic                 instr_take,
    input  wire logic                 redirect,
    input  wire logic                 gnt_done,
    input  wire mem_bus_pkg::addr_t   redirect_pc,
    input  wire mips_isa_pkg::word_t  rdata,
    output logic                      req,
    output mem_bus_pkg::addr_t        addr,
    output logic                      instr_valid,
    output mips_isa_pkg::instr_t      instr,
    output mem_bus_pkg::addr_t        instr_pc
);

    import mem_bus_pkg::*;

    logic  running;
    logic  launch;
    addr_t pc;
    addr_t next_addr;

    // A redirect overrides the sequential address.
    assign next_addr = redirect ? redirect_pc : pc;

    // New fetch only with no outstanding one and room in the buffer.
    assign launch = running && !req && (!instr_valid || instr_take);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            running     <= 1'b0;
            req         <= 1'b0;
            instr_valid <= 1'b0;
            pc          <= RESET_PC;
        end else if (start) begin
            running     <= 1'b1;
            req         <= 1'b0;
            instr_valid <= 1'b0;
            pc          <= RESET_PC;
        end else begin
            if (launch) begin
                req <= 1'b1;
                pc  <= next_addr + 32'd4;
            end else if (gnt_done) begin
                req <= 1'b0;
            end

            if (gnt_done) begin
                instr_valid <= 1'b1;
            end else if (instr_take) begin
                instr_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (launch) begin
            addr <= next_addr;
        end
        if (gnt_done) begin
            instr    <= rdata;
            instr_pc <= addr;
        end
    end

    // A redirect arrives with a take, so no wrong-path word is in flight.
    assert property (@(posedge clk) disable iff (!arst_n)
        redirect |-> !req);

endmodule

`default_nettype wire

/* source/exec_unit.sv */
`default_nettype none

module exec_unit (
    input  wire logic                 clk,
    input  wire logic                 arst_n,
    input  wire logic                 run,
    input  wire logic                 instr_valid,
    input  wire logic                 gnt_done,
    input  wire mips_isa_pkg::instr_t instr,
    input  wire mem_bus_pkg::addr_t   instr_pc,
    input  wire mips_isa_pkg::word_t  rdata,
    output logic                      instr_take,
    output logic                      start,
    output logic                      redirect,
    output logic                      req,
    output logic                      we,
    output logic                      active,
    output mem_bus_pkg::addr_t        redirect_pc,
    output mem_bus_pkg::addr_t        addr,
    output mips_isa_pkg::word_t       wdata,
    output mips_isa_pkg::word_t       register_v0
);

    import mips_isa_pkg::*;
    import mem_bus_pkg::*;

    typedef enum logic [2:0] {IDLE, EXEC, MEM, DELAY, DONE} state_t;

    state_t   state;
    opcode_t  op;
    reg_idx_t rs_idx;
    reg_idx_t rt_idx;
    reg_idx_t rd_idx;
    logic [5:0] funct;
    word_t    simm;
    word_t    rs_data;
    word_t    rt_data;
    logic     take;
    logic     mem_done;
    logic     halt_pend;
    logic     is_mem;
    logic     alu_we;
    reg_idx_t alu_rd;
    word_t    alu_result;
    logic     br_taken;
    addr_t    br_target;
    addr_t    target;
    reg_idx_t mem_rt;
    logic     rf_we;
    reg_idx_t rf_rd;
    word_t    rf_wdata;

    // Instruction fields.
    assign op     = opcode_t'(instr[31:26]);
    assign rs_idx = instr[25:21];
    assign rt_idx = instr[20:16];
    assign rd_idx = instr[15:11];
    assign funct  = instr[5:0];
    assign simm   = {{16{instr[15]}}, instr[15:0]};

    always_comb begin
        alu_we     = 1'b0;
        alu_rd     = rt_idx;
        alu_result = rs_data + simm;
        is_mem     = 1'b0;
        br_taken   = 1'b0;
        // Branch target is relative to the delay slot.
        br_target  = instr_pc + 32'd4 + (simm << 2);
        case (op)
            OP_ADDIU: alu_we = 1'b1;
            OP_SPECIAL: begin
                if (funct == FUNCT_ADDU) begin
                    alu_we     = 1'b1;
                    alu_rd     = rd_idx;
                    alu_result = rs_data + rt_data;
                end else if (funct == FUNCT_JR) begin
                    br_taken  = 1'b1;
                    br_target = rs_data;
                end
            end
            OP_REGIMM: begin
                if (rt_idx == RT_BLTZ) begin
                    br_taken = rs_data[31];
                end else if (rt_idx == RT_BGEZ) begin
                    br_taken = !rs_data[31];
                end
            end
            OP_LW, OP_SW: is_mem = 1'b1;
            default: ;
        endcase
    end

    assign take        = instr_valid && (state == EXEC || state == DELAY);
    assign instr_take  = take;
    assign start       = (state == IDLE) && run;
    assign redirect    = (state == DELAY) && take;
    assign redirect_pc = target;
    assign req         = (state == MEM);
    assign mem_done    = (state == MEM) && gnt_done;

    // Loads write back on completion, ALU ops when taken.
    assign rf_we    = (take && alu_we) || (mem_done && !we);
    assign rf_rd    = mem_done ? mem_rt : alu_rd;
    assign rf_wdata = mem_done ? rdata : alu_result;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state     <= IDLE;
            active    <= 1'b0;
            halt_pend <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (run) begin
                        state  <= EXEC;
                        active <= 1'b1;
                    end
                end
                EXEC: begin
                    if (take && is_mem) begin
                        state     <= MEM;
                        halt_pend <= 1'b0;
                    end else if (take && br_taken) begin
                        state <= DELAY;
                    end
                end
                DELAY: begin
                    if (take && is_mem) begin
                        state     <= MEM;
                        halt_pend <= (target == HALT_PC);
                    end else if (take && target == HALT_PC) begin
                        state  <= DONE;
                        active <= 1'b0;
                    end else if (take) begin
                        state <= EXEC;
                    end
                end
                MEM: begin
                    if (gnt_done && halt_pend) begin
                        state  <= DONE;
                        active <= 1'b0;
                    end else if (gnt_done) begin
                        state <= EXEC;
                    end
                end
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (take && is_mem) begin
            addr   <= rs_data + simm;
            wdata  <= rt_data;
            we     <= (op == OP_SW);
            mem_rt <= rt_idx;
        end
        if (state == EXEC && take && br_taken) begin
            target <= br_target;
        end
    end

    register_file register_file_i (
        .clk     (clk),
        .arst_n  (arst_n),
        .we      (rf_we),
        .rs      (rs_idx),
        .rt      (rt_idx),
        .rd      (rf_rd),
        .wdata   (rf_wdata),
        .rs_data (rs_data),
        .rt_data (rt_data),
        .v0      (register_v0)
    );

    // Completions only answer a pending load or store.
    assert property (@(posedge clk) disable iff (!arst_n)
        gnt_done |-> state == MEM);

endmodule

`default_nettype wire

/* source/bus_arbiter.sv */
`default_nettype none

module bus_arbiter (
    input  wire logic                clk,
    input  wire logic                arst_n,
    input  wire logic                d_req,
    input  wire logic                d_we,
    input  wire mem_bus_pkg::addr_t  d_addr,
    input  wire mips_isa_pkg::word_t d_wdata,
    output logic                     d_gnt_done,
    output mips_isa_pkg::word_t      d_rdata,
    input  wire logic                f_req,
    input  wire logic                f_we,
    input  wire mem_bus_pkg::addr_t  f_addr,
    input  wire mips_isa_pkg::word_t f_wdata,
    output logic                     f_gnt_done,
    output mips_isa_pkg::word_t      f_rdata,
    output mem_bus_pkg::addr_t       address,
    output logic                     read,
    output logic                     write,
    output mips_isa_pkg::word_t      writedata,
    input  wire logic                waitrequest,
    input  wire mips_isa_pkg::word_t readdata
);

    typedef enum logic [1:0] {OWN_NONE, OWN_DATA, OWN_FETCH} owner_t;

    owner_t owner;
    owner_t cur;
    logic   done;

    // Data wins when the bus is free.
    always_comb begin
        cur = owner;
        if (owner == OWN_NONE) begin
            if (d_req) begin
                cur = OWN_DATA;
            end else if (f_req) begin
                cur = OWN_FETCH;
            end
        end
    end

    always_comb begin
        address   = '0;
        writedata = '0;
        read      = 1'b0;
        write     = 1'b0;
        case (cur)
            OWN_DATA: begin
                address   = d_addr;
                writedata = d_wdata;
                read      = d_req && !d_we;
                write     = d_req && d_we;
            end
            OWN_FETCH: begin
                address   = f_addr;
                writedata = f_wdata;
                read      = f_req && !f_we;
                write     = f_req && f_we;
            end
            default: ;
        endcase
    end

    assign done       = (read || write) && !waitrequest;
    assign d_gnt_done = done && (cur == OWN_DATA);
    assign f_gnt_done = done && (cur == OWN_FETCH);
    assign d_rdata    = readdata;
    assign f_rdata    = readdata;

    // Owner holds the bus until its transfer completes.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            owner <= OWN_NONE;
        end else if (done) begin
            owner <= OWN_NONE;
        end else begin
            owner <= cur;
        end
    end

    // Master signals hold while the slave stalls.
    assert property (@(posedge clk) disable iff (!arst_n)
        (read || write) && waitrequest |=>
            (read || write) && $stable(write) && $stable(address));

endmodule

`default_nettype wire

/* source/avalon_ram.sv */
`default_nettype none

module avalon_ram (
    input  wire logic                  clk,
    input  wire logic                  arst_n,
    input  wire logic                  read,
    input  wire logic                  write,
    input  wire logic                  load_en,
    input  wire mem_bus_pkg::addr_t    address,
    input  wire mips_isa_pkg::word_t   writedata,
    input  wire mips_isa_pkg::word_t   load_data,
    input  wire mem_bus_pkg::ram_idx_t load_idx,
    output logic                       waitrequest,
    output mips_isa_pkg::word_t        readdata
);

    import mips_isa_pkg::*;
    import mem_bus_pkg::*;

    word_t    mem [RAM_WORDS];
    ram_idx_t idx;
    logic     access;
    logic     wait_done;

    // Word index from the byte address.
    assign idx    = address[9:2];
    assign access = read || write;

    // One wait state on every access.
    assign waitrequest = access && !wait_done;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wait_done <= 1'b0;
        end else begin
            wait_done <= access && !wait_done;
        end
    end

    always_ff @(posedge clk) begin
        if (load_en) begin
            mem[load_idx] <= load_data;
        end else if (write && wait_done) begin
            mem[idx] <= writedata;
        end
        if (read && !wait_done) begin
            readdata <= mem[idx];
        end
    end

endmodule

`default_nettype wire

/* source/mips_system.sv */
`default_nettype none

module mips_system (
    input  wire logic                  clk,
    input  wire logic                  arst_n,
    input  wire logic                  run,
    input  wire logic                  load_en,
    input  wire mem_bus_pkg::ram_idx_t load_idx,
    input  wire mips_isa_pkg::word_t   load_data,
    output logic                       active,
    output mips_isa_pkg::word_t        register_v0
);

    import mips_isa_pkg::*;
    import mem_bus_pkg::*;

    // Fetch side.
    logic   f_req;
    logic   f_gnt_done;
    addr_t  f_addr;
    word_t  f_rdata;
    logic   instr_valid;
    instr_t instr;
    addr_t  instr_pc;

    // Execute side.
    logic   instr_take;
    logic   start;
    logic   redirect;
    addr_t  redirect_pc;
    logic   d_req;
    logic   d_we;
    logic   d_gnt_done;
    addr_t  d_addr;
    word_t  d_wdata;
    word_t  d_rdata;

    // Avalon bus.
    addr_t  address;
    logic   read;
    logic   write;
    logic   waitrequest;
    word_t  writedata;
    word_t  readdata;

    fetch_unit fetch_unit_i (
        .clk(clk), .arst_n(arst_n), .start(start), .instr_take(instr_take),
        .redirect(redirect), .gnt_done(f_gnt_done), .redirect_pc(redirect_pc),
        .rdata(f_rdata), .req(f_req), .addr(f_addr), .instr_valid(instr_valid),
        .instr(instr), .instr_pc(instr_pc)
    );

    exec_unit exec_unit_i (
        .clk(clk), .arst_n(arst_n), .run(run), .instr_valid(instr_valid),
        .gnt_done(d_gnt_done), .instr(instr), .instr_pc(instr_pc), .rdata(d_rdata),
        .instr_take(instr_take), .start(start), .redirect(redirect), .req(d_req),
        .we(d_we), .active(active), .redirect_pc(redirect_pc), .addr(d_addr),
        .wdata(d_wdata), .register_v0(register_v0)
    );

    // Fetch never writes.
    bus_arbiter bus_arbiter_i (
        .clk(clk), .arst_n(arst_n),
        .d_req(d_req), .d_we(d_we), .d_addr(d_addr), .d_wdata(d_wdata),
        .d_gnt_done(d_gnt_done), .d_rdata(d_rdata),
        .f_req(f_req), .f_we(1'b0), .f_addr(f_addr), .f_wdata('0),
        .f_gnt_done(f_gnt_done), .f_rdata(f_rdata),
        .address(address), .read(read), .write(write), .writedata(writedata),
        .waitrequest(waitrequest), .readdata(readdata)
    );

    avalon_ram avalon_ram_i (
        .clk(clk), .arst_n(arst_n), .read(read), .write(write), .load_en(load_en),
        .address(address), .writedata(writedata), .load_data(load_data),
        .load_idx(load_idx), .waitrequest(waitrequest), .readdata(readdata)
    );

endmodule

`default_nettype wire

/* verif/mips_system_tb.sv */
`default_nettype none

module mips_system_tb;

    timeunit 1ns;
    timeprecision 100ps;

    import mips_isa_pkg::*;
    import mem_bus_pkg::*;

    localparam int RESET_CYCLES = 10;
    localparam int RUN_TIMEOUT  = 2000;
    // A program that must not halt is watched this long.
    localparam int WATCH_CYCLES = 500;
    localparam TESTS_FILE = "verif/mips_tests.txt";

    logic     clk = 1'b0;
    logic     arst_n;
    logic     run;
    logic     load_en;
    ram_idx_t load_idx;
    word_t    load_data;
    logic     active;
    word_t    register_v0;

    // Image of the RAM for the current test.
    word_t           prog [RAM_WORDS];
    word_t           exp_v0;
    logic            exp_halt;
    logic [8*32-1:0] test_name;
    integer          seed = 32'hf6fa_efb2;
    int              tests_run;

    always #20 clk = ~clk;

    mips_system mips_system_i (
        .clk         (clk),
        .arst_n      (arst_n),
        .run         (run),
        .load_en     (load_en),
        .load_idx    (load_idx),
        .load_data   (load_data),
        .active      (active),
        .register_v0 (register_v0)
    );

    task automatic fail_now();
        $display("Result: FAILED");
        $fatal(1, "Simulation stopped at the first error.");
    endtask

    task automatic check_word(input string what, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("** Error at %0d ns: test %0s, %0s is %h, expected %h",
                     $time, test_name, what, got, exp);
            fail_now();
        end
    endtask

    task automatic check_flag(input string what, input logic got, input logic exp);
        if (got !== exp) begin
            $display("** Error at %0d ns: test %0s, %0s flag is %b, expected %b",
                     $time, test_name, what, got, exp);
            fail_now();
        end
    endtask

    task automatic fill_memory();
        // Filler words lie outside every program path.
        for (int i = 0; i < RAM_WORDS; i++) begin
            prog[i] = $random(seed);
        end
        exp_v0   = '0;
        exp_halt = 1'b1;
    endtask

    task automatic apply_reset();
        @(posedge clk);
        arst_n  <= 1'b0;
        run     <= 1'b0;
        load_en <= 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        arst_n <= 1'b1;
    endtask

    task automatic load_program();
        for (int i = 0; i < RAM_WORDS; i++) begin
            @(posedge clk);
            load_en   <= 1'b1;
            load_idx  <= ram_idx_t'(i);
            load_data <= prog[i];
        end
        @(posedge clk);
        load_en <= 1'b0;
    endtask

    task automatic run_program();
        int   cycles;
        int   limit;
        logic halted;
        apply_reset();
        load_program();
        @(posedge clk);
        run <= 1'b1;
        cycles = 0;
        @(negedge clk);
        while (active !== 1'b1 && cycles < RUN_TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (active !== 1'b1) begin
            $display("Test %0s: the core never became active after run was raised.",
                     test_name);
            fail_now();
        end
        limit  = exp_halt ? RUN_TIMEOUT : WATCH_CYCLES;
        cycles = 0;
        while (active === 1'b1 && cycles < limit) begin
            @(negedge clk);
            cycles++;
        end
        halted = (active === 1'b0);
        if (exp_halt && !halted) begin
            $display("Test %0s: the program did not halt within %0d cycles.",
                     test_name, limit);
            fail_now();
        end
        check_flag("halt", halted, exp_halt);
        check_word("v0", register_v0, exp_v0);
        @(posedge clk);
        run <= 1'b0;
        tests_run++;
        $display("Test %0s done after %0d cycles, v0 = %h", test_name, cycles, register_v0);
    endtask

    task automatic read_tests();
        integer            fd;
        integer            code;
        logic              ok;
        logic [8*8-1:0]    kind;
        logic [8*160-1:0]  rest;
        ram_idx_t          idx;
        word_t             value;
        logic [31:0]       flag;
        fd = $fopen(TESTS_FILE, "r");
        if (fd == 0) begin
            $display("Cannot open the test file %0s.", TESTS_FILE);
            fail_now();
        end
        code = $fscanf(fd, "%s", kind);
        while (code == 1) begin
            ok = 1'b1;
            if (kind == "#") begin
                code = $fgets(rest, fd);
            end else if (kind == "T") begin
                code = $fscanf(fd, "%s", test_name);
                ok   = (code == 1);
                fill_memory();
            end else if (kind == "P") begin
                code = $fscanf(fd, "%h %h", idx, value);
                ok   = (code == 2);
                prog[idx] = value;
            end else if (kind == "E") begin
                code   = $fscanf(fd, "%h", value);
                ok     = (code == 1);
                exp_v0 = value;
            end else if (kind == "H") begin
                code = $fscanf(fd, "%d", flag);
                ok   = (code == 1) && (flag <= 1);
                exp_halt = flag[0];
                if (ok) begin
                    run_program();
                end
            end else begin
                ok = 1'b0;
            end
            if (!ok) begin
                $display("The test file has a malformed record of kind %0s.", kind);
                fail_now();
            end
            code = $fscanf(fd, "%s", kind);
        end
        $fclose(fd);
    endtask

    initial begin
        arst_n    = 1'b0;
        run       = 1'b0;
        load_en   = 1'b0;
        load_idx  = '0;
        load_data = '0;
        tests_run = 0;
        read_tests();
        if (tests_run == 0) begin
            $display("No complete test was found in %0s.", TESTS_FILE);
            fail_now();
        end else begin
            $display("Result: PASSED");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* verif/mips_tests.txt */
# Records: T name | P word_index word (hex) | E expected_v0 (hex) | H halt_flag (0 or 1)
# Execution starts at word 1, JR to address 0 halts after its delay slot.
T arith
P 01 24020064
P 02 2408fff6
P 03 00481021
P 04 2409ff38
P 05 00491021
P 06 2442ffff
P 07 00000008
P 08 00000000
E ffffff91
H 1
# Not taken BLTZ and BGEZ, then taken BLTZ and BGEZ with delay slots.
T branch_fwd
P 01 2408ffff
P 02 24090005
P 03 05200004
P 04 24420001
P 05 24420002
P 06 05010004
P 07 24420004
P 08 24420008
P 09 05000002
P 0a 24420010
P 0b 24420100
P 0c 05210002
P 0d 24420020
P 0e 24420200
P 0f 00000008
P 10 00000000
E 3f
H 1
# Four passes through a BGEZ loop, 0x28 added per pass.
T branch_back
P 01 24080003
P 02 24420020
P 03 2508ffff
P 04 0501fffd
P 05 24420008
P 06 00000008
P 07 00000000
E a0
H 1
# SW then LW of the same word, LW of a loaded word, SW in the halt delay slot.
T store_load
P 01 24081234
P 02 24090200
P 03 ad280004
P 04 8d220004
P 05 8d2a0008
P 06 004a1021
P 07 00000008
P 08 ad22000c
P 82 00000100
E 1334
H 1
T reg_zero
P 01 24000055
P 02 24080007
P 03 01080021
P 04 24020033
P 05 00001021
P 06 00000008
P 07 00000000
E 0
H 1
# JR to word 8 skips words 4 to 7.
T jump_far
P 01 24080020
P 02 01000008
P 03 24420001
P 04 24420040
P 08 24420010
P 09 00000008
P 0a 00000000
E 11
H 1
# Endless JR loop must keep the core active.
T no_halt
P 01 24020077
P 02 24080008
P 03 01000008
P 04 00000000
E 77
H 0

/* flist.f */
source/mips_isa_pkg.sv
source/mem_bus_pkg.sv
source/register_file.sv
source/fetch_unit.sv
source/exec_unit.sv
source/bus_arbiter.sv
source/avalon_ram.sv
source/mips_system.sv
verif/mips_system_tb.sv

/* Bender.yml */
package:
  name: mips_system

sources:
  - source/mips_isa_pkg.sv
  - source/mem_bus_pkg.sv
  - source/register_file.sv
  - source/fetch_unit.sv
  - source/exec_unit.sv
  - source/bus_arbiter.sv
  - source/avalon_ram.sv
  - source/mips_system.sv
  - target: simulation
    files:
      - verif/mips_system_tb.sv
